// ==== Makefile ====
# Verilator build and run of the tile pipe testbench

SIM  := obj_dir/Vtb_sf_tile_pipe
SRCS := $(shell cat sf_tile_pipe.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) sf_tile_pipe.f
	verilator --binary --timing --assert -j 0 --top-module tb_sf_tile_pipe -f sf_tile_pipe.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sf_palette_mixer.sv ====
// palette register file, colour lookup and composite blanking
`timescale 1ns/10ps

module sf_palette_mixer #(
   parameter int NUM_PLANES = 3
) (
   input  logic                    clk,
   input  logic                    CR,
   input  logic                    pix_cen_i,
   input  logic [NUM_PLANES-1:0]   color_idx_i,
   input  logic                    blank_i,
   input  logic                    pal_we_i,
   input  logic [NUM_PLANES-1:0]   pal_addr_i,
   input  sf_video_pkg::rgb_t      pal_data_i,
   output sf_video_pkg::rgb_t      rgb_o
);

   // one entry per colour index
   localparam int PAL_DEPTH = 1 << NUM_PLANES;

   sf_video_pkg::rgb_t pal_mem [PAL_DEPTH];
   sf_video_pkg::rgb_t pal_rd;

   // ==================================================
   // palette
   // ==================================================

   // written by the strobe, cleared to black by reset
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         for (int i = 0; i < PAL_DEPTH; i++)
         begin
            pal_mem[i] <= '0;
         end
      end
      else if (pal_we_i)
      begin
         pal_mem[pal_addr_i] <= pal_data_i;
      end
   end

   // lookup of the pixel currently at the shifter outputs
   assign pal_rd = pal_mem[color_idx_i];

   // ==================================================
   // output stage
   // ==================================================

   // one new colour per pixel enable, black while blanked
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         rgb_o <= '0;
      end
      else if (pix_cen_i)
      begin
         if (blank_i)
         begin
            rgb_o <= '0;
         end
         else
         begin
            rgb_o <= pal_rd;
         end
      end
   end

endmodule

// ==== sf_pixel_cen.sv ====
// pixel clock-enable divider
`timescale 1ns/10ps

module sf_pixel_cen #(
   parameter int PIX_DIV = 8
) (
   input  logic clk,
   input  logic CR,
   output logic pix_cen_o
);

   localparam int CNT_W = $clog2(PIX_DIV);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PIX_DIV - 1);

   logic [CNT_W-1:0] div_cnt;

   // ==================================================
   // divider
   // ==================================================

   // counts 0 .. PIX_DIV-1 and fires on the wrap
   // so the first enable comes PIX_DIV edges after reset
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_cnt   <= '0;
         pix_cen_o <= 1'b0;
      end
      else if (div_cnt == CNT_LAST)
      begin
         div_cnt   <= '0;
         pix_cen_o <= 1'b1;
      end
      else
      begin
         div_cnt   <= div_cnt + 1'b1;
         pix_cen_o <= 1'b0;
      end
   end

endmodule

// ==== sf_plane_shifter.sv ====
// single bitplane load/shift register with hold
`timescale 1ns/10ps

module sf_plane_shifter (
   input  logic                       clk,
   input  logic                       CR,
   input  sf_timing_pkg::shift_mode_t mode_i,
   input  sf_video_pkg::tile_row_t    row_i,
   output logic                       pixel_o
);

   sf_video_pkg::tile_row_t q;

   // ==================================================
   // ls194 style register
   // ==================================================

   // HOLD doubles as the clock enable
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         q <= '0;
      end
      else
      begin
         case (mode_i)
            sf_timing_pkg::LOAD:
            begin
               q <= row_i;
            end
            sf_timing_pkg::SHIFT:
            begin
               // toward the msb, zero fills from below
               q <= {q[sf_video_pkg::TILE_W-2:0], 1'b0};
            end
            default:
            begin
               q <= q;
            end
         endcase
      end
   end

   // serial out is the top bit
   assign pixel_o = q[sf_video_pkg::TILE_W-1];

endmodule

// ==== sf_tile_loader.sv ====
// tile-row holding register, pixel counter and shift-mode control
`timescale 1ns/10ps

module sf_tile_loader #(
   parameter int NUM_PLANES = 3
) (
   input  logic                                     clk,
   input  logic                                     CR,
   input  logic                                     pix_cen_i,
   input  logic                                     tile_load_i,
   input  sf_video_pkg::tile_row_t [NUM_PLANES-1:0] tile_rows_i,
   input  logic                                     tile_flip_i,
   output sf_timing_pkg::shift_mode_t               shift_mode_o,
   output sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows_o,
   output sf_timing_pkg::hpos_t                     hpos_o
);

   // next tile, waiting for the boundary
   sf_video_pkg::tile_row_t [NUM_PLANES-1:0] hold_rows;
   logic                                     hold_flip;

   sf_timing_pkg::hpos_t hpos;
   logic                 at_boundary;

   // ==================================================
   // holding register
   // ==================================================

   // a later strobe simply overwrites the earlier one
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         hold_rows <= '0;
         hold_flip <= 1'b0;
      end
      else if (tile_load_i)
      begin
         hold_rows <= tile_rows_i;
         hold_flip <= tile_flip_i;
      end
   end

   // ==================================================
   // pixel position
   // ==================================================

   // starts at the boundary so the first enable loads
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         hpos <= sf_timing_pkg::HPOS_LAST;
      end
      else if (pix_cen_i)
      begin
         hpos <= hpos + sf_timing_pkg::hpos_t'(1);
      end
   end

   assign hpos_o      = hpos;
   assign at_boundary = (hpos == sf_timing_pkg::HPOS_LAST);

   // ==================================================
   // shifter control
   // ==================================================

   always_comb
   begin
      if (!pix_cen_i)
      begin
         shift_mode_o = sf_timing_pkg::HOLD;
      end
      else if (at_boundary)
      begin
         shift_mode_o = sf_timing_pkg::LOAD;
      end
      else
      begin
         shift_mode_o = sf_timing_pkg::SHIFT;
      end
   end

   // horizontal flip is a bit reversal of every plane's row
   always_comb
   begin
      for (int p = 0; p < NUM_PLANES; p++)
      begin
         for (int b = 0; b < sf_video_pkg::TILE_W; b++)
         begin
            rows_o[p][b] = hold_flip ? hold_rows[p][sf_video_pkg::TILE_W-1-b]
                                     : hold_rows[p][b];
         end
      end
   end

endmodule

// ==== sf_tile_pipe.f ====
sf_video_pkg.sv
sf_timing_pkg.sv
sf_pixel_cen.sv
sf_tile_loader.sv
sf_plane_shifter.sv
sf_palette_mixer.sv
sf_tile_pipe.sv
tb_sf_tile_pipe.sv

// ==== sf_tile_pipe.sv ====
// graphics output path top level: pixel enable, tile loader, plane shifters, mixer
`timescale 1ns/10ps

module sf_tile_pipe #(
   parameter int NUM_PLANES = 3,
   parameter int PIX_DIV    = 8
) (
   input  logic                                     clk,
   input  logic                                     CR,
   input  logic                                     tile_load_i,
   input  sf_video_pkg::tile_row_t [NUM_PLANES-1:0] tile_rows_i,
   input  logic                                     tile_flip_i,
   input  logic                                     pal_we_i,
   input  logic [NUM_PLANES-1:0]                    pal_addr_i,
   input  sf_video_pkg::rgb_t                       pal_data_i,
   input  logic                                     blank_i,
   output sf_video_pkg::rgb_t                       rgb_o,
   output logic                                     pix_cen_o,
   output sf_timing_pkg::hpos_t                     hpos_o
);

   logic                                     pix_cen;
   sf_timing_pkg::shift_mode_t               shift_mode;
   sf_video_pkg::tile_row_t [NUM_PLANES-1:0] plane_rows;
   logic [NUM_PLANES-1:0]                    color_idx;

   // ==================================================
   // pixel enable and row control
   // ==================================================

   sf_pixel_cen #(
      .PIX_DIV (PIX_DIV)
   ) u_pixel_cen (
      .clk       (clk),
      .CR        (CR),
      .pix_cen_o (pix_cen)
   );

   assign pix_cen_o = pix_cen;

   sf_tile_loader #(
      .NUM_PLANES (NUM_PLANES)
   ) u_tile_loader (
      .clk          (clk),
      .CR           (CR),
      .pix_cen_i    (pix_cen),
      .tile_load_i  (tile_load_i),
      .tile_rows_i  (tile_rows_i),
      .tile_flip_i  (tile_flip_i),
      .shift_mode_o (shift_mode),
      .rows_o       (plane_rows),
      .hpos_o       (hpos_o)
   );

   // ==================================================
   // bitplane shifters
   // ==================================================

   // plane p supplies bit p of the colour index
   for (genvar p = 0; p < NUM_PLANES; p++)
   begin : gen_plane
      sf_plane_shifter u_shifter (
         .clk     (clk),
         .CR      (CR),
         .mode_i  (shift_mode),
         .row_i   (plane_rows[p]),
         .pixel_o (color_idx[p])
      );
   end

   sf_palette_mixer #(
      .NUM_PLANES (NUM_PLANES)
   ) u_palette_mixer (
      .clk         (clk),
      .CR          (CR),
      .pix_cen_i   (pix_cen),
      .color_idx_i (color_idx),
      .blank_i     (blank_i),
      .pal_we_i    (pal_we_i),
      .pal_addr_i  (pal_addr_i),
      .pal_data_i  (pal_data_i),
      .rgb_o       (rgb_o)
   );

endmodule

// ==== sf_timing_pkg.sv ====
// shift-mode encoding and pixel-position type for the tile shifters

package sf_timing_pkg;

   // ==================================================
   // shift register select
   // ==================================================

   // ls194 select codes, left shift (10) is never issued
   typedef enum logic [1:0] {
      HOLD  = 2'b00,
      SHIFT = 2'b01,
      LOAD  = 2'b11
   } shift_mode_t;

   // ==================================================
   // pixel position
   // ==================================================

   localparam int HPOS_W = 3;

   // pixel index within a tile row
   typedef logic [HPOS_W-1:0] hpos_t;

   // last pixel of a row, tile boundary
   localparam hpos_t HPOS_LAST = 3'd7;

endpackage

// ==== sf_video_pkg.sv ====
// colour and tile-row types for the graphics output path

package sf_video_pkg;

   // ==================================================
   // pixel widths
   // ==================================================

   // pixels per tile row
   localparam int TILE_W = 8;

   // output colour width, 3-3-2
   localparam int RGB_W = 8;

   // ==================================================
   // types
   // ==================================================

   // red [7:5], green [4:2], blue [1:0]
   typedef logic [RGB_W-1:0] rgb_t;

   // one bitplane row, msb is the leftmost pixel when unflipped
   typedef logic [TILE_W-1:0] tile_row_t;

endpackage

// ==== tb_sf_tile_pipe.sv ====
// testbench for the tile pipe: clock, reset, stimulus, reference model and checking assertions
`timescale 1ns/10ps

module tb_sf_tile_pipe;

   localparam int NUM_PLANES = 3;
   localparam int PIX_DIV    = 8;
   localparam int PAL_DEPTH  = 1 << NUM_PLANES;
   localparam int WAIT_LIMIT = PIX_DIV * 10;

   logic                                     clk = 1'b0;
   logic                                     CR;
   logic                                     tile_load_i;
   sf_video_pkg::tile_row_t [NUM_PLANES-1:0] tile_rows_i;
   logic                                     tile_flip_i;
   logic                                     pal_we_i;
   logic [NUM_PLANES-1:0]                    pal_addr_i;
   sf_video_pkg::rgb_t                       pal_data_i;
   logic                                     blank_i;
   sf_video_pkg::rgb_t                       rgb_o;
   logic                                     pix_cen_o;
   sf_timing_pkg::hpos_t                     hpos_o;

   int          errors   = 0;
   int          timeouts = 0;
   int          pixels   = 0;
   logic [31:0] lfsr     = 32'hcd5d3146;

   // reference model state
   int                                       m_div;
   logic                                     m_cen;
   sf_timing_pkg::hpos_t                     m_hpos;
   sf_video_pkg::rgb_t                       m_rgb;
   logic                                     m_blanked;
   sf_video_pkg::tile_row_t [NUM_PLANES-1:0] m_hold_rows;
   logic                                     m_hold_flip;
   sf_video_pkg::tile_row_t [NUM_PLANES-1:0] m_cur_rows;
   logic                                     m_cur_flip;
   sf_video_pkg::rgb_t                       m_pal [PAL_DEPTH];

   sf_tile_pipe #(
      .NUM_PLANES (NUM_PLANES),
      .PIX_DIV    (PIX_DIV)
   ) UUT (
      .clk         (clk),
      .CR          (CR),
      .tile_load_i (tile_load_i),
      .tile_rows_i (tile_rows_i),
      .tile_flip_i (tile_flip_i),
      .pal_we_i    (pal_we_i),
      .pal_addr_i  (pal_addr_i),
      .pal_data_i  (pal_data_i),
      .blank_i     (blank_i),
      .rgb_o       (rgb_o),
      .pix_cen_o   (pix_cen_o),
      .hpos_o      (hpos_o)
   );

   always #5 clk = ~clk;

   // ==================================================
   // helpers
   // ==================================================

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // index bit p is pixel k of plane p, leftmost pixel first unless flipped
   function automatic logic [NUM_PLANES-1:0] pixel_index(
      input sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows,
      input logic                                     flip,
      input sf_timing_pkg::hpos_t                     k
   );
      logic [NUM_PLANES-1:0] idx;
      for (int p = 0; p < NUM_PLANES; p++)
      begin
         idx[p] = flip ? rows[p][k] : rows[p][3'd7 - k];
      end
      return idx;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic random_rows(output sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows);
      logic [31:0] bits;
      for (int p = 0; p < NUM_PLANES; p++)
      begin
         take_bits(8, bits);
         rows[p] = bits[7:0];
      end
   endtask

   task automatic write_pal(input logic [NUM_PLANES-1:0] addr, input sf_video_pkg::rgb_t data);
      pal_we_i   = 1'b1;
      pal_addr_i = addr;
      pal_data_i = data;
      @(posedge clk);
      #1;
      pal_we_i   = 1'b0;
   endtask

   task automatic load_tile(
      input sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows,
      input logic                                     flip
   );
      tile_load_i = 1'b1;
      tile_rows_i = rows;
      tile_flip_i = flip;
      @(posedge clk);
      #1;
      tile_load_i = 1'b0;
   endtask

   // returns just after the pixel enable edge that leaves hpos target
   task automatic wait_hpos(input sf_timing_pkg::hpos_t target);
      int   n;
      logic found;
      n     = 0;
      found = 1'b0;
      while (!found && n < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         n++;
         found = pix_cen_o && (hpos_o == target);
      end
      if (found)
      begin
         @(posedge clk);
         #1;
      end
      else
      begin
         timeouts++;
         $display("timeout: no pixel enable at position %0d within %0d cycles", target, n);
      end
   endtask

   // flip_mode 0 never, 1 always, 2 random
   task automatic run_tiles(input int count, input int flip_mode);
      sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows;
      logic [31:0]                              bits;
      logic                                     flip;
      for (int t = 0; t < count; t++)
      begin
         random_rows(rows);
         take_bits(1, bits);
         flip = (flip_mode == 2) ? bits[0] : (flip_mode == 1);
         load_tile(rows, flip);
         wait_hpos(3'd7);
      end
   endtask

   // ==================================================
   // reference model
   // ==================================================

   always @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         m_div       <= 0;
         m_cen       <= 1'b0;
         m_hpos      <= 3'd7;
         m_rgb       <= '0;
         m_blanked   <= 1'b0;
         m_hold_rows <= '0;
         m_hold_flip <= 1'b0;
         m_cur_rows  <= '0;
         m_cur_flip  <= 1'b0;
         for (int i = 0; i < PAL_DEPTH; i++)
         begin
            m_pal[i] <= '0;
         end
      end
      else
      begin
         if (m_cen)
         begin
            m_blanked <= blank_i;
            m_rgb     <= blank_i ? '0 : m_pal[pixel_index(m_cur_rows, m_cur_flip, m_hpos)];
            m_hpos    <= m_hpos + 3'd1;
            pixels    <= pixels + 1;
            // tile boundary, the held tile moves into the shifters
            if (m_hpos == 3'd7)
            begin
               m_cur_rows <= m_hold_rows;
               m_cur_flip <= m_hold_flip;
            end
         end
         if (tile_load_i)
         begin
            m_hold_rows <= tile_rows_i;
            m_hold_flip <= tile_flip_i;
         end
         if (pal_we_i)
         begin
            m_pal[pal_addr_i] <= pal_data_i;
         end
         m_cen <= (m_div == PIX_DIV - 1);
         m_div <= (m_div == PIX_DIV - 1) ? 0 : m_div + 1;
      end
   end

   // ==================================================
   // checks, sampled on the falling edge
   // ==================================================

   reset_values: assert property (@(negedge clk)
      CR || (rgb_o == '0 && !pix_cen_o && hpos_o == 3'd7))
      else
      begin
         errors++;
         $display("[FAIL] reset values: rgb_o %h pix_cen_o %h hpos_o %h",
                  rgb_o, pix_cen_o, hpos_o);
      end

   cen_match: assert property (@(negedge clk) pix_cen_o == m_cen)
      else
      begin
         errors++;
         $display("[FAIL] pix_cen_o: got %h, expected %h", pix_cen_o, m_cen);
      end

   hpos_match: assert property (@(negedge clk) hpos_o == m_hpos)
      else
      begin
         errors++;
         $display("[FAIL] hpos_o: got %h, expected %h", hpos_o, m_hpos);
      end

   rgb_match: assert property (@(negedge clk) rgb_o == m_rgb)
      else
      begin
         errors++;
         $display("[FAIL] rgb_o: got %h, expected %h", rgb_o, m_rgb);
      end

   blank_black: assert property (@(negedge clk) !m_blanked || rgb_o == '0)
      else
      begin
         errors++;
         $display("[FAIL] rgb_o while blanked: got %h, expected %h", rgb_o, 8'h00);
      end

   // ==================================================
   // stimulus
   // ==================================================

   initial
   begin : stimulus
      sf_video_pkg::tile_row_t [NUM_PLANES-1:0] rows;
      logic [31:0]                              bits;
      CR          = 1'b1;
      tile_load_i = 1'b0;
      tile_rows_i = '0;
      tile_flip_i = 1'b0;
      pal_we_i    = 1'b0;
      pal_addr_i  = '0;
      pal_data_i  = '0;
      blank_i     = 1'b0;
      @(posedge clk);
      #1;
      CR = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      CR = 1'b1;

      for (int i = 0; i < PAL_DEPTH; i++)
      begin
         take_bits(8, bits);
         write_pal(NUM_PLANES'(i), bits[7:0]);
      end

      run_tiles(10, 0);
      run_tiles(6, 1);
      run_tiles(6, 2);

      // two strobes inside one tile, the second one wins
      wait_hpos(3'd2);
      random_rows(rows);
      load_tile(rows, 1'b0);
      wait_hpos(3'd4);
      random_rows(rows);
      load_tile(rows, 1'b1);
      wait_hpos(3'd7);
      run_tiles(2, 2);

      // blank pixels 2..5 and rewrite half the palette meanwhile
      wait_hpos(3'd1);
      blank_i = 1'b1;
      for (int i = 0; i < PAL_DEPTH / 2; i++)
      begin
         take_bits(8, bits);
         write_pal(NUM_PLANES'(2 * i + 1), bits[7:0]);
      end
      wait_hpos(3'd5);
      blank_i = 1'b0;
      run_tiles(4, 2);
      wait_hpos(3'd7);

      $display("pixels checked: %0d, errors: %0d, timeouts: %0d", pixels, errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("Everything OK");
      end
      else
      begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
